/* video_board_pkg.sv */
package video_board_pkg;

    // Game side colour width per channel
    localparam int COLORW  = 4;
    // One extra bit after the bandwidth filter
    localparam int CLROUTW = COLORW + 1;
    // Display side colour width
    localparam int OUTW    = 8;

    // OSD status word fields
    localparam int STATUS_BW_BIT = 5;
    localparam int STATUS_SL_LSB = 3;

    typedef enum logic [1:0] {
        SL_NONE    = 2'd0,
        SL_HALF    = 2'd1,
        SL_QUARTER = 2'd2,
        SL_BLACK   = 2'd3
    } sl_mode_e;

    typedef struct packed {
        logic     bw_en;
        sl_mode_e sl_mode;
    } settings_t;

    // Pixel as delivered by the game core
    typedef struct packed {
        logic [COLORW-1:0] r;
        logic [COLORW-1:0] g;
        logic [COLORW-1:0] b;
        logic              lhbl;
        logic              lvbl;
        logic              hs;
        logic              vs;
    } pixel_t;

    // Same pixel after the bandwidth filter
    typedef struct packed {
        logic [CLROUTW-1:0] r;
        logic [CLROUTW-1:0] g;
        logic [CLROUTW-1:0] b;
        logic               lhbl;
        logic               lvbl;
        logic               hs;
        logic               vs;
    } wide_pixel_t;

endpackage

/* video_settings.sv */
module video_settings (
    input  logic                       clk_sys,
    input  logic                       rst,
    input  logic                       vs,
    input  logic [63:0]                status,
    output video_board_pkg::settings_t settings
);

    logic vs_l;
    logic vs_rise;

    assign vs_rise = vs & ~vs_l;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            vs_l <= 1'b0;
        end else begin
            vs_l <= vs;
        end
    end

    // Settings only move at a frame start, so no frame is shown half old, half new
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            settings.bw_en   <= 1'b0;
            settings.sl_mode <= video_board_pkg::SL_NONE;
        end else if (vs_rise) begin
            settings.bw_en   <= status[video_board_pkg::STATUS_BW_BIT];
            settings.sl_mode <= video_board_pkg::sl_mode_e'(
                status[video_board_pkg::STATUS_SL_LSB +: 2]);
        end
    end

endmodule

/* video_capture.sv */
module video_capture (
    input  logic                                  clk_sys,
    input  logic                                  rst,
    input  logic                                  pxl_cen,
    input  logic [video_board_pkg::COLORW-1:0]    game_r,
    input  logic [video_board_pkg::COLORW-1:0]    game_g,
    input  logic [video_board_pkg::COLORW-1:0]    game_b,
    input  logic                                  lhbl,
    input  logic                                  lvbl,
    input  logic                                  hs,
    input  logic                                  vs,
    output video_board_pkg::pixel_t               pix,
    output logic                                  pix_valid
);

    // Pixel data is only sampled on the pixel clock enable
    always_ff @(posedge clk_sys) begin
        if (pxl_cen) begin
            pix.r    <= game_r;
            pix.g    <= game_g;
            pix.b    <= game_b;
            pix.lhbl <= lhbl;
            pix.lvbl <= lvbl;
            pix.hs   <= hs;
            pix.vs   <= vs;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            pix_valid <= 1'b0;
        end else begin
            pix_valid <= pxl_cen;
        end
    end

endmodule

/* video_bw_filter.sv */
module video_bw_filter (
    input  logic                           clk_sys,
    input  logic                           rst,
    input  video_board_pkg::settings_t     settings,
    input  video_board_pkg::pixel_t        pix,
    input  logic                           pix_valid,
    output video_board_pkg::wide_pixel_t   wpix,
    output logic                           wpix_valid
);

    logic [video_board_pkg::COLORW-1:0] prev_r;
    logic [video_board_pkg::COLORW-1:0] prev_g;
    logic [video_board_pkg::COLORW-1:0] prev_b;

    // Two-tap sum acts as a slow analog wire, plain doubling otherwise
    function automatic logic [video_board_pkg::CLROUTW-1:0] filt_chan(
        input logic [video_board_pkg::COLORW-1:0] cur,
        input logic [video_board_pkg::COLORW-1:0] prev,
        input logic                               en
    );
        if (en) begin
            filt_chan = {1'b0, cur} + {1'b0, prev};
        end else begin
            filt_chan = {cur, 1'b0};
        end
    endfunction

    // Previous active pixel, blanking restarts the line at black
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            prev_r <= '0;
            prev_g <= '0;
            prev_b <= '0;
        end else if (pix_valid) begin
            prev_r <= pix.lhbl ? pix.r : '0;
            prev_g <= pix.lhbl ? pix.g : '0;
            prev_b <= pix.lhbl ? pix.b : '0;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (pix_valid) begin
            wpix.r    <= filt_chan(pix.r, prev_r, settings.bw_en);
            wpix.g    <= filt_chan(pix.g, prev_g, settings.bw_en);
            wpix.b    <= filt_chan(pix.b, prev_b, settings.bw_en);
            wpix.lhbl <= pix.lhbl;
            wpix.lvbl <= pix.lvbl;
            wpix.hs   <= pix.hs;
            wpix.vs   <= pix.vs;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            wpix_valid <= 1'b0;
        end else begin
            wpix_valid <= pix_valid;
        end
    end

endmodule

/* video_scanline_out.sv */
module video_scanline_out (
    input  logic                                clk_sys,
    input  logic                                rst,
    input  video_board_pkg::settings_t          settings,
    input  video_board_pkg::wide_pixel_t        wpix,
    input  logic                                wpix_valid,
    output logic [video_board_pkg::OUTW-1:0]    scan2x_r,
    output logic [video_board_pkg::OUTW-1:0]    scan2x_g,
    output logic [video_board_pkg::OUTW-1:0]    scan2x_b,
    output logic                                scan2x_hs,
    output logic                                scan2x_vs,
    output logic                                scan2x_de,
    output logic                                scan2x_cen
);

    logic line_odd;
    logic hs_l;
    logic odd_nx;
    logic de;

    // Extend to 8 bits and apply the scanline rule on odd lines
    function automatic logic [video_board_pkg::OUTW-1:0] shade(
        input logic [video_board_pkg::CLROUTW-1:0] c,
        input video_board_pkg::sl_mode_e           mode,
        input logic                                odd
    );
        logic [video_board_pkg::OUTW-1:0] x;
        x = {c, c[video_board_pkg::CLROUTW-1 -:
                  (video_board_pkg::OUTW - video_board_pkg::CLROUTW)]};
        if (!odd) begin
            shade = x;
        end else begin
            case (mode)
                video_board_pkg::SL_HALF:    shade = x >> 1;
                video_board_pkg::SL_QUARTER: shade = x - (x >> 2);
                video_board_pkg::SL_BLACK:   shade = '0;
                default:                     shade = x;
            endcase
        end
    endfunction

    // The pixel that starts a line already counts on the new line
    always_comb begin
        if (wpix.vs) begin
            odd_nx = 1'b0;
        end else if (wpix.hs && !hs_l) begin
            odd_nx = ~line_odd;
        end else begin
            odd_nx = line_odd;
        end
    end

    assign de = wpix.lhbl & wpix.lvbl;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            line_odd <= 1'b0;
            hs_l     <= 1'b0;
        end else if (wpix_valid) begin
            line_odd <= odd_nx;
            hs_l     <= wpix.hs;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            scan2x_r   <= '0;
            scan2x_g   <= '0;
            scan2x_b   <= '0;
            scan2x_hs  <= 1'b0;
            scan2x_vs  <= 1'b0;
            scan2x_de  <= 1'b0;
            scan2x_cen <= 1'b0;
        end else begin
            scan2x_cen <= wpix_valid;
            if (wpix_valid) begin
                // Black out the blanking interval
                scan2x_r  <= de ? shade(wpix.r, settings.sl_mode, odd_nx) : '0;
                scan2x_g  <= de ? shade(wpix.g, settings.sl_mode, odd_nx) : '0;
                scan2x_b  <= de ? shade(wpix.b, settings.sl_mode, odd_nx) : '0;
                scan2x_hs <= wpix.hs;
                scan2x_vs <= wpix.vs;
                scan2x_de <= de;
            end
        end
    end

endmodule

/* video_board.sv */
module video_board (
    input  logic                                clk_sys,
    input  logic                                rst,
    input  logic                                pxl_cen,
    input  logic [video_board_pkg::COLORW-1:0]  game_r,
    input  logic [video_board_pkg::COLORW-1:0]  game_g,
    input  logic [video_board_pkg::COLORW-1:0]  game_b,
    input  logic                                lhbl,
    input  logic                                lvbl,
    input  logic                                hs,
    input  logic                                vs,
    input  logic [63:0]                         status,
    output logic [video_board_pkg::OUTW-1:0]    scan2x_r,
    output logic [video_board_pkg::OUTW-1:0]    scan2x_g,
    output logic [video_board_pkg::OUTW-1:0]    scan2x_b,
    output logic                                scan2x_hs,
    output logic                                scan2x_vs,
    output logic                                scan2x_de,
    output logic                                scan2x_cen
);

    video_board_pkg::settings_t   settings;
    video_board_pkg::pixel_t      pix;
    logic                         pix_valid;
    video_board_pkg::wide_pixel_t wpix;
    logic                         wpix_valid;

    video_settings u_settings (
        .clk_sys  ( clk_sys  ),
        .rst      ( rst      ),
        .vs       ( vs       ),
        .status   ( status   ),
        .settings ( settings )
    );

    video_capture u_capture (
        .clk_sys   ( clk_sys   ),
        .rst       ( rst       ),
        .pxl_cen   ( pxl_cen   ),
        .game_r    ( game_r    ),
        .game_g    ( game_g    ),
        .game_b    ( game_b    ),
        .lhbl      ( lhbl      ),
        .lvbl      ( lvbl      ),
        .hs        ( hs        ),
        .vs        ( vs        ),
        .pix       ( pix       ),
        .pix_valid ( pix_valid )
    );

    // Game video goes straight into the filter
    video_bw_filter u_bw_filter (
        .clk_sys    ( clk_sys    ),
        .rst        ( rst        ),
        .settings   ( settings   ),
        .pix        ( pix        ),
        .pix_valid  ( pix_valid  ),
        .wpix       ( wpix       ),
        .wpix_valid ( wpix_valid )
    );

    video_scanline_out u_scanline_out (
        .clk_sys    ( clk_sys    ),
        .rst        ( rst        ),
        .settings   ( settings   ),
        .wpix       ( wpix       ),
        .wpix_valid ( wpix_valid ),
        .scan2x_r   ( scan2x_r   ),
        .scan2x_g   ( scan2x_g   ),
        .scan2x_b   ( scan2x_b   ),
        .scan2x_hs  ( scan2x_hs  ),
        .scan2x_vs  ( scan2x_vs  ),
        .scan2x_de  ( scan2x_de  ),
        .scan2x_cen ( scan2x_cen )
    );

endmodule

/* video_board_chk.sv */
module video_board_chk (
    input logic                                  clk_sys,
    input logic                                  rst,
    input logic                                  pxl_cen,
    input video_board_pkg::pixel_t               pin,
    input logic [63:0]                           status,
    input logic [3*video_board_pkg::OUTW-1:0]    out_rgb,
    // cen, de, hs, vs
    input logic [3:0]                            out_ctl
);

    video_board_pkg::settings_t        set_m;
    video_board_pkg::pixel_t           in_p;
    video_board_pkg::pixel_t           last_p;
    video_board_pkg::wide_pixel_t      mid_p;
    logic                              vs_d;
    logic                              in_v;
    logic                              mid_v;
    logic                              odd_m;
    logic                              hs_m;
    logic                              rst_q;
    logic                              fail_seen;
    logic [3*video_board_pkg::OUTW-1:0] exp_rgb;
    logic [3:0]                        exp_ctl;

    // Filter output, plain doubling when the filter is off
    function automatic logic [video_board_pkg::CLROUTW-1:0] widen(
        input logic [video_board_pkg::COLORW-1:0] cur,
        input logic [video_board_pkg::COLORW-1:0] prev,
        input logic                               bw
    );
        logic [video_board_pkg::CLROUTW-1:0] a;
        logic [video_board_pkg::CLROUTW-1:0] p;
        a = {1'b0, cur};
        p = {1'b0, prev};
        widen = bw ? a + p : a + a;
    endfunction

    // Top bits repeated below the colour, then the scanline rule
    function automatic logic [video_board_pkg::OUTW-1:0] shade_ref(
        input logic [video_board_pkg::CLROUTW-1:0] c,
        input video_board_pkg::sl_mode_e           mode,
        input logic                                odd
    );
        logic [video_board_pkg::OUTW-1:0] x;
        x = '0;
        x[video_board_pkg::CLROUTW-1:0] = c;
        x = (x << (video_board_pkg::OUTW - video_board_pkg::CLROUTW))
            | (x >> (2 * video_board_pkg::CLROUTW - video_board_pkg::OUTW));
        if (odd) begin
            case (mode)
                video_board_pkg::SL_HALF:    x = x >> 1;
                video_board_pkg::SL_QUARTER: x = x - (x >> 2);
                video_board_pkg::SL_BLACK:   x = '0;
                default:                     x = x;
            endcase
        end
        shade_ref = x;
    endfunction

    // vs forces even, an hs rising edge toggles
    function automatic logic parity(
        input logic                         odd,
        input logic                         prev_hs,
        input video_board_pkg::wide_pixel_t p
    );
        parity = p.vs ? 1'b0 : odd ^ (p.hs & ~prev_hs);
    endfunction

    always_ff @(posedge clk_sys) begin
        rst_q <= rst;
        if (rst) begin
            set_m   <= '0;
            vs_d    <= 1'b0;
            in_v    <= 1'b0;
            mid_v   <= 1'b0;
            last_p  <= '0;
            odd_m   <= 1'b0;
            hs_m    <= 1'b0;
            exp_rgb <= '0;
            exp_ctl <= '0;
        end else begin
            vs_d <= pin.vs;
            if (pin.vs && !vs_d) begin
                set_m.bw_en   <= status[video_board_pkg::STATUS_BW_BIT];
                set_m.sl_mode <= video_board_pkg::sl_mode_e'(
                    status[video_board_pkg::STATUS_SL_LSB +: 2]);
            end
            in_v <= pxl_cen;
            if (pxl_cen) begin
                in_p <= pin;
            end
            mid_v <= in_v;
            if (in_v) begin
                mid_p.r <= widen(in_p.r, last_p.r, set_m.bw_en);
                mid_p.g <= widen(in_p.g, last_p.g, set_m.bw_en);
                mid_p.b <= widen(in_p.b, last_p.b, set_m.bw_en);
                {mid_p.lhbl, mid_p.lvbl, mid_p.hs, mid_p.vs}
                    <= {in_p.lhbl, in_p.lvbl, in_p.hs, in_p.vs};
                last_p <= in_p.lhbl ? in_p : '0;
            end
            exp_ctl[3] <= mid_v;
            if (mid_v) begin
                odd_m        <= parity(odd_m, hs_m, mid_p);
                hs_m         <= mid_p.hs;
                exp_ctl[2:0] <= {mid_p.lhbl & mid_p.lvbl, mid_p.hs, mid_p.vs};
                exp_rgb      <= (mid_p.lhbl & mid_p.lvbl) ? {
                    shade_ref(mid_p.r, set_m.sl_mode, parity(odd_m, hs_m, mid_p)),
                    shade_ref(mid_p.g, set_m.sl_mode, parity(odd_m, hs_m, mid_p)),
                    shade_ref(mid_p.b, set_m.sl_mode, parity(odd_m, hs_m, mid_p))} : '0;
            end
        end
    end

    // Outputs settle after the rising edge, compared half a cycle later
    always_ff @(negedge clk_sys) begin
        if (rst_q) begin
            fail_seen <= 1'b0;
        end else if ({out_rgb, out_ctl} != {exp_rgb, exp_ctl}) begin
            fail_seen <= 1'b1;
        end
    end

    a_cen: assert property (@(negedge clk_sys) disable iff (rst_q) out_ctl[3] == exp_ctl[3])
        else $error("mismatch at %0t: scan2x_cen expected %0b actual %0b",
                    $time, exp_ctl[3], out_ctl[3]);
    a_de: assert property (@(negedge clk_sys) disable iff (rst_q) out_ctl[2] == exp_ctl[2])
        else $error("mismatch at %0t: scan2x_de expected %0b actual %0b",
                    $time, exp_ctl[2], out_ctl[2]);
    a_sync: assert property (@(negedge clk_sys) disable iff (rst_q)
                             out_ctl[1:0] == exp_ctl[1:0])
        else $error("mismatch at %0t: scan2x_hs/vs expected %b actual %b",
                    $time, exp_ctl[1:0], out_ctl[1:0]);
    a_rgb: assert property (@(negedge clk_sys) disable iff (rst_q) out_rgb == exp_rgb)
        else $error("mismatch at %0t: scan2x_rgb expected %h actual %h",
                    $time, exp_rgb, out_rgb);

endmodule

bind video_board video_board_chk u_chk (
    .clk_sys ( clk_sys ),
    .rst     ( rst ),
    .pxl_cen ( pxl_cen ),
    .pin     ( {game_r, game_g, game_b, lhbl, lvbl, hs, vs} ),
    .status  ( status ),
    .out_rgb ( {scan2x_r, scan2x_g, scan2x_b} ),
    .out_ctl ( {scan2x_cen, scan2x_de, scan2x_hs, scan2x_vs} )
);

/* tb_clock.sv */
module tb_clock (
    output logic clk_sys
);

    initial begin
        clk_sys = 1'b0;
    end

    // Half period of 5 gives a 10 unit clock
    always #5 clk_sys = ~clk_sys;

endmodule

/* video_board_tb.sv */
module video_board_tb;

    localparam int LINE_PIX     = 40;
    localparam int ACTIVE_PIX   = 32;
    localparam int HS_START     = 34;
    localparam int HS_LEN       = 3;
    localparam int FRAME_LINES  = 12;
    localparam int ACTIVE_LINES = 10;
    // One frame per bw and scanline combination
    localparam int N_FRAMES     = 8;
    localparam int RESET_CYCLES = 8;
    // Bound assumes every frame runs at half rate and adds margin for the drain
    localparam int MAX_RUN        = RESET_CYCLES + N_FRAMES * FRAME_LINES * LINE_PIX * 2;
    localparam int TIMEOUT_CYCLES = (MAX_RUN / 1000 + 3) * 1000;

    logic                                clk_sys;
    logic                                rst;
    logic                                pxl_cen;
    logic [video_board_pkg::COLORW-1:0]  game_r;
    logic [video_board_pkg::COLORW-1:0]  game_g;
    logic [video_board_pkg::COLORW-1:0]  game_b;
    logic                                lhbl;
    logic                                lvbl;
    logic                                hs;
    logic                                vs;
    logic [63:0]                         status;
    logic [video_board_pkg::OUTW-1:0]    scan2x_r;
    logic [video_board_pkg::OUTW-1:0]    scan2x_g;
    logic [video_board_pkg::OUTW-1:0]    scan2x_b;
    logic                                scan2x_hs;
    logic                                scan2x_vs;
    logic                                scan2x_de;
    logic                                scan2x_cen;

    int seed;
    int in_count = 0;
    int out_count = 0;
    int cycle_count = 0;

    tb_clock u_clock (
        .clk_sys ( clk_sys )
    );

    video_board uut (.*);

    task automatic pick_colours();
        logic [31:0] rnd;
        rnd    = $random(seed);
        game_r = rnd[0 +: video_board_pkg::COLORW];
        game_g = rnd[video_board_pkg::COLORW +: video_board_pkg::COLORW];
        game_b = rnd[2 * video_board_pkg::COLORW +: video_board_pkg::COLORW];
    endtask

    // Other status bits carry noise the decoder has to ignore
    task automatic set_status(input int combo);
        logic [31:0] rnd;
        rnd    = $random(seed);
        status = {rnd, ~rnd};
        status[video_board_pkg::STATUS_BW_BIT]      = combo[2];
        status[video_board_pkg::STATUS_SL_LSB +: 2] = combo[1:0];
    endtask

    task automatic send_pixel(input int line, input int col, input logic full_rate);
        @(negedge clk_sys);
        pxl_cen  = 1'b1;
        pick_colours();
        lhbl     = (col < ACTIVE_PIX);
        lvbl     = (line < ACTIVE_LINES);
        hs       = (col >= HS_START) && (col < HS_START + HS_LEN);
        vs       = (line >= ACTIVE_LINES);
        in_count = in_count + 1;
        if (!full_rate) begin
            @(negedge clk_sys);
            pxl_cen = 1'b0;
            // Colour noise between strobes must not reach the output
            pick_colours();
        end
    endtask

    always @(negedge clk_sys) begin
        if (scan2x_cen) begin
            out_count <= out_count + 1;
        end
    end

    always @(posedge clk_sys) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: output pixels stopped arriving");
            $display("Regression failed");
            $fatal(1, "cycle limit of %0d reached", TIMEOUT_CYCLES);
        end else if (uut.u_chk.fail_seen) begin
            $display("Regression failed");
            $fatal(1, "checker assertion failed before %0t", $time);
        end
    end

    initial begin
        seed    = 32'h6369_3f18;
        rst     = 1'b1;
        pxl_cen = 1'b0;
        game_r  = '0;
        game_g  = '0;
        game_b  = '0;
        lhbl    = 1'b0;
        lvbl    = 1'b0;
        hs      = 1'b0;
        vs      = 1'b0;
        status  = '0;
        repeat (RESET_CYCLES) @(posedge clk_sys);
        @(negedge clk_sys);
        rst = 1'b0;
        // Outputs must stay low in this idle gap before the first pixel
        repeat (4) @(negedge clk_sys);
        for (int f = 0; f < N_FRAMES; f++) begin
            // First frame starts one line in, so an odd count of hs edges meets the first vs
            for (int line = (f == 0) ? 1 : 0; line < FRAME_LINES; line++) begin
                for (int col = 0; col < LINE_PIX; col++) begin
                    // Status changes mid-frame and only takes hold after the next vs
                    if (line == FRAME_LINES / 2 && col == 0) begin
                        set_status((f + 1) % N_FRAMES);
                    end
                    send_pixel(line, col, f >= N_FRAMES / 2);
                end
            end
        end
        @(negedge clk_sys);
        pxl_cen = 1'b0;
        while (out_count < in_count) begin
            @(posedge clk_sys);
        end
        repeat (2) @(posedge clk_sys);
        if (uut.u_chk.fail_seen) begin
            $display("Regression failed");
            $fatal(1, "checker flagged a wrong output");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

/* video_board.f */
video_board_pkg.sv
video_settings.sv
video_capture.sv
video_bw_filter.sv
video_scanline_out.sv
video_board.sv
video_board_chk.sv
tb_clock.sv
video_board_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench, then look for the pass line in the log
rm -f sim.log
verilator --binary --assert -j 0 -f video_board.f --top-module video_board_tb && \
    ./obj_dir/Vvideo_board_tb +verilator+error+limit+100 2>&1 | tee sim.log
grep -q "^Regression passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
